// File: byteFifo.sv
`timescale 1ns/10ps

module byteFifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            push,
    input  logic [uartPkg::byteWidth-1:0]   wrData,
    input  logic                            pop,
    output logic [uartPkg::byteWidth-1:0]   rdData,
    output logic                            full,
    output logic                            empty
);

    localparam int addrWidth = $clog2(FIFO_DEPTH);

    logic [uartPkg::byteWidth-1:0] mem [FIFO_DEPTH];

    // Extra MSB tells a full buffer from an empty one
    logic [addrWidth:0] wrPtr;
    logic [addrWidth:0] rdPtr;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr[addrWidth-1:0]] <= wrData;
        end
    end

    // Head byte falls through without a read cycle
    assign rdData = mem[rdPtr[addrWidth-1:0]];

    assign empty = (wrPtr == rdPtr);
    assign full  = (wrPtr[addrWidth] != rdPtr[addrWidth]) &&
                   (wrPtr[addrWidth-1:0] == rdPtr[addrWidth-1:0]);

    ////////////////////////////////////////
    // Protocol checks on both neighbours
    ////////////////////////////////////////

    assert property (@(posedge clk) disable iff (!rstN) push |-> !full)
        else $error("byteFifo: write into a full FIFO");

    assert property (@(posedge clk) disable iff (!rstN) pop |-> !empty)
        else $error("byteFifo: read from an empty FIFO");

endmodule

// File: debugUart.sv
`timescale 1ns/10ps

module debugUart #(
    parameter int CLKS_PER_BIT   = uartPkg::defaultClksPerBit,
    parameter int HOLDOFF_CYCLES = dumpPkg::defaultHoldoff,
    parameter int FIFO_DEPTH     = 4
) (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            btnDump,
    input  logic [dumpPkg::wordWidth-1:0]   debugWord,
    output logic                            uartTx
);

    // Sequencer to FIFO
    logic                          push;
    logic [uartPkg::byteWidth-1:0] wrData;
    logic                          full;

    // FIFO to transmitter
    logic [uartPkg::byteWidth-1:0] rdData;
    logic                          empty;
    logic                          pop;

    dumpSequencer #(
        .HOLDOFF_CYCLES(HOLDOFF_CYCLES)
    ) uSequencer (
        .clk       (clk),
        .rstN      (rstN),
        .btnDump   (btnDump),
        .debugWord (debugWord),
        .full      (full),
        .push      (push),
        .wrData    (wrData)
    );

    byteFifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) uFifo (
        .clk    (clk),
        .rstN   (rstN),
        .push   (push),
        .wrData (wrData),
        .pop    (pop),
        .rdData (rdData),
        .full   (full),
        .empty  (empty)
    );

    uartTransmitter #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) uTransmitter (
        .clk    (clk),
        .rstN   (rstN),
        .rdData (rdData),
        .empty  (empty),
        .pop    (pop),
        .uartTx (uartTx)
    );

endmodule

// File: dumpPkg.sv
package dumpPkg;

    ////////////////////////////////////////
    // Debug word layout
    ////////////////////////////////////////

    // Word presented by the CPU
    localparam int wordWidth = 32;

    // Bytes sent per dump, MSB first
    localparam int bytesPerWord = 4;

    // Cycles the button is ignored after a dump
    localparam int defaultHoldoff = 1048575;

    // Dump sequencer FSM
    typedef enum logic [1:0] {
        seqIdle,
        seqPush,
        seqHoldoff,
        seqWaitRelease
    } seqStateT;

endpackage

// File: dumpSequencer.sv
`timescale 1ns/10ps

module dumpSequencer #(
    parameter int HOLDOFF_CYCLES = dumpPkg::defaultHoldoff
) (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            btnDump,
    input  logic [dumpPkg::wordWidth-1:0]   debugWord,
    input  logic                            full,
    output logic                            push,
    output logic [uartPkg::byteWidth-1:0]   wrData
);

    localparam int idxWidth  = $clog2(dumpPkg::bytesPerWord);
    localparam int holdWidth = (HOLDOFF_CYCLES > 1) ? $clog2(HOLDOFF_CYCLES) : 1;

    dumpPkg::seqStateT seqState;

    logic [dumpPkg::wordWidth-1:0] capturedWord;
    logic [idxWidth-1:0]           byteIdx;
    logic [holdWidth-1:0]          holdCnt;
    logic                          pressed;
    logic                          canPush;
    logic                          lastByte;
    logic                          holdDone;

    assign pressed  = (seqState == dumpPkg::seqIdle) && !btnDump;

    // Push is registered, so a byte in flight is not yet counted in full.
    // Skipping the cycle after each push keeps full accurate when we look at it.
    assign canPush  = (seqState == dumpPkg::seqPush) && !full && !push;

    assign lastByte = (byteIdx == idxWidth'(dumpPkg::bytesPerWord - 1));
    assign holdDone = (holdCnt == holdWidth'(HOLDOFF_CYCLES - 1));

    ////////////////////////////////////////
    // Control
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            seqState <= dumpPkg::seqIdle;
            byteIdx  <= '0;
            holdCnt  <= '0;
            push     <= 1'b0;
        end else begin
            push <= canPush;

            case (seqState)
                dumpPkg::seqIdle: begin
                    if (pressed) begin
                        seqState <= dumpPkg::seqPush;
                        byteIdx  <= '0;
                    end
                end

                dumpPkg::seqPush: begin
                    if (canPush) begin
                        byteIdx <= byteIdx + 1'b1;
                        if (lastByte) begin
                            seqState <= dumpPkg::seqHoldoff;
                            holdCnt  <= '0;
                        end
                    end
                end

                dumpPkg::seqHoldoff: begin
                    if (holdDone) begin
                        seqState <= dumpPkg::seqWaitRelease;
                    end else begin
                        holdCnt <= holdCnt + 1'b1;
                    end
                end

                dumpPkg::seqWaitRelease: begin
                    // Button must be let go before the next dump
                    if (btnDump) begin
                        seqState <= dumpPkg::seqIdle;
                    end
                end

                default: begin
                    seqState <= dumpPkg::seqIdle;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // Word capture and byte split
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (pressed) begin
            capturedWord <= debugWord;
        end else if (canPush) begin
            // Next byte moves up to the top
            capturedWord <= capturedWord << uartPkg::byteWidth;
        end

        if (canPush) begin
            wrData <= capturedWord[dumpPkg::wordWidth-1 -: uartPkg::byteWidth];
        end
    end

    // Back-pressure from the FIFO must never cost a byte
    assert property (@(posedge clk) disable iff (!rstN) push |-> !full)
        else $error("dumpSequencer: push while FIFO full");

endmodule

// File: files.f
uartPkg.sv
dumpPkg.sv
dumpSequencer.sv
byteFifo.sv
uartTransmitter.sv
debugUart.sv
tbDebugUart.sv

// File: run.sh
#!/bin/sh
# Compile and run the debug UART testbench, then grade the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tbDebugUart -f files.f \
    && ./obj_dir/VtbDebugUart > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q "TEST FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "No pass result in log"; exit 1; }
exit 0

// File: tbDebugUart.sv
`timescale 1ns/10ps

module tbDebugUart;

    localparam int clksPerBit    = 8;
    localparam int holdoffCycles = 40;
    localparam int fifoDepth     = 2;
    localparam int clkPeriod     = 20;
    localparam int numDumps      = 8;
    localparam int maxHold       = 450;
    localparam int frameBits     = 10;
    localparam int byteBits      = 8;
    localparam int bytesPerDump  = 4;

    // Four frames per dump plus the longest hold, hold-off and gaps
    localparam int dumpNs    = bytesPerDump * frameBits * clksPerBit * clkPeriod
                             + (holdoffCycles + maxHold + 100) * clkPeriod;
    localparam int timeoutNs = numDumps * dumpNs + 500 * clkPeriod;

    localparam int dumpWaitCycles = bytesPerDump * (frameBits * clksPerBit + 1)
                                  + holdoffCycles + 50;

    // With a two-byte FIFO the last push waits for the first frame to end,
    // so hold-off starts right after press latency plus one frame
    localparam int firstFrameEnd = 4 + frameBits * clksPerBit;

    logic        clk;
    logic        rstN;
    logic        btnDump;
    logic [31:0] debugWord;
    logic        uartTx;

    integer seed = 73797;

    int         checkErrors;
    int         otherErrors;
    int         framesDecoded;
    bit         modelBusy;
    bit         latencyPending;
    time        pressEdgeTime;
    logic [7:0] expQ [$];

    initial clk = 1'b0;
    always #(clkPeriod / 2) clk = ~clk;

    debugUart #(
        .CLKS_PER_BIT   (clksPerBit),
        .HOLDOFF_CYCLES (holdoffCycles),
        .FIFO_DEPTH     (fifoDepth)
    ) UUT (
        .clk       (clk),
        .rstN      (rstN),
        .btnDump   (btnDump),
        .debugWord (debugWord),
        .uartTx    (uartTx)
    );

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string msg);
        if (actual !== expected) begin
            checkErrors++;
            $display("CHECK FAILED at %0t ns: %s (got 0x%0h, expected 0x%0h)",
                     $time, msg, actual, expected);
        end
    endtask

    function automatic int randRange(input int lo, input int hi);
        int r;
        r = $random(seed);
        return lo + int'($unsigned(r) % (hi - lo + 1));
    endfunction

    // One clock of stimulus with a fresh random word on the bus
    task automatic driveCycle(input logic btn);
        @(posedge clk);
        #1;
        btnDump   = btn;
        debugWord = $random(seed);
    endtask

    // Button goes down; the model decides whether the sequencer takes it
    task automatic pressCycle();
        logic [31:0] w;
        int          i;
        @(posedge clk);
        #1;
        w         = $random(seed);
        btnDump   = 1'b0;
        debugWord = w;
        if (!modelBusy) begin
            // MSB byte goes out first
            for (i = bytesPerDump - 1; i >= 0; i--) begin
                expQ.push_back(w[i*byteBits +: byteBits]);
            end
            modelBusy      = 1'b1;
            latencyPending = 1'b1;
            pressEdgeTime  = $time + clkPeriod - 1;
        end
    endtask

    task automatic waitDumpDone();
        int cycles;
        cycles = 0;
        while (expQ.size() != 0 && cycles < dumpWaitCycles) begin
            @(posedge clk);
            cycles++;
        end
        if (expQ.size() != 0) begin
            otherErrors++;
            $display("Dump did not finish at %0t ns, %0d bytes never arrived",
                     $time, expQ.size());
            expQ.delete();
        end
        // Hold-off is long over by now and the button is up
        modelBusy = 1'b0;
    endtask

    ////////////////////////////////////////
    // Serial line decoder
    ////////////////////////////////////////

    initial begin : serialDecoder
        logic [frameBits-1:0]  frame;
        logic [clksPerBit-1:0] samples;
        logic                  level;
        logic [7:0]            expByte;
        time                   fallTime;
        int                    b;
        int                    s;
        int                    unstable;
        forever begin
            @(negedge uartTx);
            fallTime = $time;
            if (latencyPending) begin
                checkValue(32'(fallTime - pressEdgeTime), 32'(4 * clkPeriod),
                           "press edge to first start bit in ns");
                latencyPending = 1'b0;
            end
            // One sample per falling clock edge and the mid-bit sample decides
            for (b = 0; b < frameBits; b++) begin
                for (s = 0; s < clksPerBit; s++) begin
                    @(negedge clk);
                    samples[s] = uartTx;
                end
                level    = samples[clksPerBit/2];
                unstable = 0;
                for (s = 0; s < clksPerBit; s++) begin
                    if (samples[s] !== level) begin
                        unstable++;
                    end
                end
                checkValue(unstable, 0,
                           $sformatf("bit %0d of frame %0d not held for a bit time",
                                     b, framesDecoded));
                frame[b] = level;
            end
            framesDecoded++;
            checkValue(32'(frame[0]), 32'(1'b0), "start bit level");
            checkValue(32'(frame[frameBits-1]), 32'(1'b1), "stop bit level");
            if (expQ.size() == 0) begin
                otherErrors++;
                $display("Unexpected frame at %0t ns carrying 0x%02h with no dump pending",
                         $time, frame[byteBits:1]);
            end else begin
                expByte = expQ.pop_front();
                checkValue(32'(frame[byteBits:1]), 32'(expByte), "data byte");
            end
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    initial begin : stimulus
        int dump;
        int idleCycles;
        int holdLen;
        int extras;
        int gap;
        int i;
        int j;

        rstN           = 1'b0;
        btnDump        = 1'b1;
        debugWord      = '0;
        checkErrors    = 0;
        otherErrors    = 0;
        framesDecoded  = 0;
        modelBusy      = 1'b0;
        latencyPending = 1'b0;
        pressEdgeTime  = 0;

        repeat (3) @(posedge clk);
        #1;
        rstN = 1'b1;

        // Quiet line before any press
        idleCycles = randRange(10, 30);
        for (i = 0; i < idleCycles; i++) begin
            driveCycle(1'b1);
            @(negedge clk);
            checkValue(32'(uartTx), 32'(1'b1), "line idle after reset");
        end

        for (dump = 0; dump < numDumps; dump++) begin
            idleCycles = randRange(2, 20);
            repeat (idleCycles) driveCycle(1'b1);
            pressCycle();
            if (randRange(0, 2) == 0) begin
                // Long hold runs through hold-off into the release wait
                holdLen = randRange(150, maxHold);
                repeat (holdLen) driveCycle(1'b0);
            end else begin
                holdLen = randRange(0, 40);
                repeat (holdLen) driveCycle(1'b0);
                repeat (firstFrameEnd - holdLen) driveCycle(1'b1);
                // Extra presses land inside hold-off
                extras = randRange(0, 3);
                for (j = 0; j < extras; j++) begin
                    gap = randRange(2, 4);
                    repeat (gap) driveCycle(1'b1);
                    pressCycle();
                    holdLen = randRange(0, 3);
                    repeat (holdLen) driveCycle(1'b0);
                end
            end
            driveCycle(1'b1);
            waitDumpDone();
        end

        // Room for any stray frame to show up
        repeat (3 * frameBits * clksPerBit) @(posedge clk);
        checkValue(expQ.size(), 0, "expected bytes left over");
        checkValue(framesDecoded, numDumps * bytesPerDump, "frames decoded");

        $display("Errors: %0d check failures, %0d other failures", checkErrors, otherErrors);
        if (checkErrors == 0 && otherErrors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #(timeoutNs);
        $display("Timeout after %0d ns, the run never reached its end", timeoutNs);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: uartPkg.sv
package uartPkg;

    ////////////////////////////////////////
    // Serial line timing
    ////////////////////////////////////////

    // Data byte carried by one frame
    localparam int byteWidth = 8;

    // 27 MHz system clock at 115200 baud
    localparam int defaultClksPerBit = 234;

    ////////////////////////////////////////
    // 8N1 frame layout
    ////////////////////////////////////////

    localparam logic idleLevel  = 1'b1;
    localparam logic startLevel = 1'b0;
    localparam logic stopLevel  = 1'b1;

    // Transmitter FSM
    typedef enum logic [1:0] {
        txIdle,
        txStart,
        txData,
        txStop
    } txStateT;

endpackage

// File: uartTransmitter.sv
`timescale 1ns/10ps

module uartTransmitter #(
    parameter int CLKS_PER_BIT = uartPkg::defaultClksPerBit
) (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic [uartPkg::byteWidth-1:0]   rdData,
    input  logic                            empty,
    output logic                            pop,
    output logic                            uartTx
);

    localparam int cntWidth = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam int idxWidth = $clog2(uartPkg::byteWidth);

    uartPkg::txStateT txState;

    logic [cntWidth-1:0]           clkCnt;
    logic [idxWidth-1:0]           bitIdx;
    logic [uartPkg::byteWidth-1:0] shiftByte;
    logic                          txLine;
    logic                          bitDone;
    logic                          lastBit;

    assign bitDone = (clkCnt == cntWidth'(CLKS_PER_BIT - 1));
    assign lastBit = (bitIdx == idxWidth'(uartPkg::byteWidth - 1));

    // Take the head byte as soon as the line is free
    assign pop = (txState == uartPkg::txIdle) && !empty;

    assign uartTx = txLine;

    ////////////////////////////////////////
    // Frame FSM
    ////////////////////////////////////////

    // The line register follows the state one cycle later
    always_ff @(posedge clk) begin
        if (!rstN) begin
            txState <= uartPkg::txIdle;
            clkCnt  <= '0;
            bitIdx  <= '0;
            txLine  <= uartPkg::idleLevel;
        end else begin
            case (txState)
                uartPkg::txIdle: begin
                    txLine <= uartPkg::idleLevel;
                    clkCnt <= '0;
                    if (pop) begin
                        txState <= uartPkg::txStart;
                    end
                end

                uartPkg::txStart: begin
                    txLine <= uartPkg::startLevel;
                    if (bitDone) begin
                        clkCnt  <= '0;
                        bitIdx  <= '0;
                        txState <= uartPkg::txData;
                    end else begin
                        clkCnt <= clkCnt + 1'b1;
                    end
                end

                uartPkg::txData: begin
                    // LSB first
                    txLine <= shiftByte[0];
                    if (bitDone) begin
                        clkCnt <= '0;
                        bitIdx <= bitIdx + 1'b1;
                        if (lastBit) begin
                            txState <= uartPkg::txStop;
                        end
                    end else begin
                        clkCnt <= clkCnt + 1'b1;
                    end
                end

                uartPkg::txStop: begin
                    txLine <= uartPkg::stopLevel;
                    if (bitDone) begin
                        clkCnt  <= '0;
                        txState <= uartPkg::txIdle;
                    end else begin
                        clkCnt <= clkCnt + 1'b1;
                    end
                end

                default: begin
                    txState <= uartPkg::txIdle;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // Data shifter
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (pop) begin
            shiftByte <= rdData;
        end else if (txState == uartPkg::txData && bitDone) begin
            shiftByte <= shiftByte >> 1;
        end
    end

    // First Stop cycle still shows the last data bit through the line register
    assert property (@(posedge clk) disable iff (!rstN)
        (txState == uartPkg::txIdle || (txState == uartPkg::txStop && clkCnt != '0))
            |-> uartTx)
        else $error("uartTransmitter: line low outside a start or data bit");

endmodule
